// ==== verilog.f ====
+incdir+hw
hw/clkgen_pkg.sv
hw/clkdiv_counter.sv
hw/clkdiv_edges.sv
hw/clkdiv_outsel.sv
hw/clkdiv_top.sv
verif/tb_clock.sv
verif/tb_clkdiv.sv

// ==== Makefile ====
# build and run the clock generator testbench with Verilator

TOP := tb_clkdiv

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o $(TOP)

# verdict comes from the pass line in the simulator output
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// ==== verif/tb_clkdiv.sv ====
/* config changes are applied only once the model count is back at 0,
   so a smaller period never leaves the count stranded above it */
`timescale 1ns/1ps
`include "clkgen_config.svh"

module tb_clkdiv;

   localparam int CW   = `CLKDIV_CW;
   localparam int PW   = `CLKDIV_PW;
   localparam int ST_W = $clog2(`CLKDIV_STABLE_PERIODS);
   localparam logic [ST_W-1:0] ST_MAX = ST_W'(`CLKDIV_STABLE_PERIODS - 1);

   localparam int DRIVE_DLY    = 2;   // ns after rising edge
   localparam int RESET_CYCLES = 4;
   localparam int N_FIX = 3;          // fixed ratios
   localparam int FIX_LEN = 80;
   localparam int N_RND = 6;          // random sweep configs
   localparam int RND_LEN = 96;
   localparam int BYP_LEN = 32;
   localparam int HALF_LEN = 40;
   localparam int STALL_LEN = 120;
   localparam int TOTAL = RESET_CYCLES + N_FIX * FIX_LEN + N_RND * RND_LEN
                        + BYP_LEN + HALF_LEN + STALL_LEN;
   localparam int LIMIT = TOTAL * 3 / 2;

   logic          clk;
   logic          nreset;
   logic          clkchange;
   logic          clken;
   logic [CW-1:0] clkdiv;
   logic [PW-1:0] clkphase0;
   logic [PW-1:0] clkphase1;
   logic          clkout0;
   logic          clkrise0;
   logic          clkfall0;
   logic          clkout1;
   logic          clkrise1;
   logic          clkfall1;
   logic          clkstable;

   // ####################
   // model state
   // ####################
   logic [CW-1:0]   m_count = '0;
   logic [ST_W-1:0] m_stable = '0;      // period matches since change
   logic            m_wave0 = 1'b0;
   logic            m_wave1 = 1'b0;
   logic            m_wave1_prev = 1'b0; // wave1 one cycle back, for the shift
   logic            m_chg_last = 1'b0;   // change pulse seen at last edge

   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   logic [31:0] rng = 32'd94;           // xorshift state

   tb_clock #(
      .PERIOD       (40),
      .RESET_CYCLES (RESET_CYCLES),
      .RELEASE_DLY  (DRIVE_DLY)
   ) u_clock (
      .clk    (clk),
      .nreset (nreset)
   );

   clkdiv_top uut (
      .clk       (clk),
      .nreset    (nreset),
      .clkchange (clkchange),
      .clken     (clken),
      .clkdiv    (clkdiv),
      .clkphase0 (clkphase0),
      .clkphase1 (clkphase1),
      .clkout0   (clkout0),
      .clkrise0  (clkrise0),
      .clkfall0  (clkfall0),
      .clkout1   (clkout1),
      .clkrise1  (clkrise1),
      .clkfall1  (clkfall1),
      .clkstable (clkstable)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // strobe is a plain equality against one phase half
   function automatic logic hit(input logic [CW-1:0] cnt, input logic [CW-1:0] half);
      return cnt == half;
   endfunction

   // ####################
   // reference, one rising edge
   // ####################
   function automatic void ref_step(
      input  logic [CW-1:0]   cnt,
      input  logic [ST_W-1:0] stb,
      input  logic            w0,
      input  logic            w1,
      input  logic            en,
      input  logic            chg,
      input  logic [CW-1:0]   div,
      input  logic [PW-1:0]   ph0,
      input  logic [PW-1:0]   ph1,
      output logic [CW-1:0]   n_cnt,
      output logic [ST_W-1:0] n_stb,
      output logic            n_w0,
      output logic            n_w1
   );
      logic match;
      match = (cnt == div);
      n_cnt = en ? (match ? '0 : cnt + 1'b1) : cnt;  // held while disabled
      if (chg) begin
         n_stb = '0;
      end else if (match && stb != ST_MAX) begin
         n_stb = stb + 1'b1;   // counts matches even when stalled
      end else begin
         n_stb = stb;
      end
      // set on rise, clear on fall only, rise first
      n_w0 = hit(cnt, ph0[CW-1:0]) ? 1'b1 : (hit(cnt, ph0[PW-1:CW]) ? 1'b0 : w0);
      n_w1 = hit(cnt, ph1[CW-1:0]) ? 1'b1 : (hit(cnt, ph1[PW-1:CW]) ? 1'b0 : w1);
   endfunction

   task automatic check(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic drive_point();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic rand_below(input int n, output logic [CW-1:0] v);
      rng = xorshift32(rng);
      v = CW'(rng % 32'(n));
   endtask

   task automatic apply_config(input logic [CW-1:0] div, input logic [PW-1:0] ph0,
                               input logic [PW-1:0] ph1);
      while (m_count != '0) begin
         drive_point();       // wait for the wrap, bounded by the timeout
      end
      clkdiv = div;
      clkphase0 = ph0;
      clkphase1 = ph1;
      clkchange = 1'b1;
      drive_point();
      clkchange = 1'b0;       // one-cycle pulse
   endtask

   task automatic run_stall(input int n);
      repeat (n) begin
         rng = xorshift32(rng);
         clken = rng[0] | rng[1];   // enabled about 3 cycles of 4
         drive_point();
      end
      clken = 1'b1;
   endtask

   // model advances on the same edges as the DUT
   always @(posedge clk) begin
      if (nreset) begin
         m_wave1_prev = m_wave1;
         m_chg_last = clkchange;
         ref_step(m_count, m_stable, m_wave0, m_wave1, clken, clkchange, clkdiv,
                  clkphase0, clkphase1, m_count, m_stable, m_wave0, m_wave1);
      end
   end

   // ####################
   // comparing process
   // ####################
   initial begin : compare
      logic active;
      logic out_ok;   // mode settled since last low phase
      forever begin
         @(posedge clk);
         active = nreset;
         #10;                       // high phase
         out_ok = active && !clkchange;
         if (out_ok && clkdiv == '0) begin
            check("clkout0", clkout0, 1'b1);
            check("clkout1", clkout1, 1'b1);
         end
         if (out_ok && clkdiv == CW'(1)) begin
            check("clkout1", clkout1, m_wave1_prev);   // still the old half cycle
         end
         #20;                       // low phase, 10 ns past the falling edge
         if (out_ok && clkdiv == '0) begin
            check("clkout0", clkout0, 1'b0);
            check("clkout1", clkout1, 1'b0);
         end else if (out_ok) begin
            check("clkout0", clkout0, m_wave0);
            if (clkdiv != CW'(1)) begin
               check("clkout1", clkout1, m_wave1);
            end
         end
         #8;                        // just before the next rising edge
         if (active) begin
            check("clkrise0", clkrise0, hit(m_count, clkphase0[CW-1:0]));
            check("clkfall0", clkfall0, hit(m_count, clkphase0[PW-1:CW]));
            check("clkrise1", clkrise1, hit(m_count, clkphase1[CW-1:0]));
            check("clkfall1", clkfall1, hit(m_count, clkphase1[PW-1:CW]));
            check("clkstable", clkstable, m_stable == ST_MAX);
            if (m_chg_last) begin
               check("clkstable", clkstable, 1'b0);
            end
            if (out_ok && clkdiv == CW'(1)) begin
               check("clkout1", clkout1, m_wave1);   // shifted copy caught up
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= LIMIT) begin
         $display("timeout: test did not finish within %0d cycles", LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   // ####################
   // stimulus
   // ####################
   initial begin : stimulus
      logic [CW-1:0] div;
      logic [CW-1:0] r0;
      logic [CW-1:0] f0;
      logic [CW-1:0] r1;
      logic [CW-1:0] f1;
      clkchange = 1'b0;
      clken = 1'b1;
      clkdiv = '0;
      clkphase0 = '0;
      clkphase1 = '0;
      wait (nreset);
      drive_point();

      for (int i = 0; i < N_FIX; i++) begin
         div = (i == 0) ? CW'(2) : ((i == 1) ? CW'(3) : CW'(5));
         apply_config(div, {(div + 1'b1) >> 1, CW'(0)}, {div, CW'(1)});
         run_cycles(FIX_LEN);
      end

      // random ratios 2..9, phase halves within the period
      for (int i = 0; i < N_RND; i++) begin
         rand_below(8, div);
         div = div + CW'(2);
         rand_below(int'(div) + 1, r0);
         rand_below(int'(div) + 1, f0);
         rand_below(int'(div) + 1, r1);
         rand_below(int'(div) + 1, f1);
         apply_config(div, {f0, r0}, {f1, r1});
         run_cycles(RND_LEN);
      end

      apply_config('0, '0, '0);                    // bypass
      run_cycles(BYP_LEN);
      apply_config(CW'(1), {CW'(1), CW'(0)}, {CW'(1), CW'(0)});  // divide by 2
      run_cycles(HALF_LEN);
      apply_config(CW'(4), {CW'(2), CW'(0)}, {CW'(4), CW'(1)});
      run_stall(STALL_LEN);
      drive_point();

      $display("run done: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   task automatic run_cycles(input int n);
      repeat (n) begin
         drive_point();
      end
   endtask

endmodule

// ==== verif/tb_clock.sv ====
/* free-running clock, reset low for a fixed number of rising edges
   reset release lands a small delay after an edge, never on it */
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD       = 40,  // ns
   parameter int RESET_CYCLES = 4,
   parameter int RELEASE_DLY  = 2    // ns after the rising edge
) (
   output logic clk,
   output logic nreset              // async, active low
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      nreset = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #RELEASE_DLY;
      nreset = 1'b1;                 // same offset as the stimulus
   end

endmodule

// ==== hw/clkdiv_top.sv ====
/* two-output clock generator; configuration changes must come with a
   one-cycle clkchange pulse, phase values are not checked */
`timescale 1ns/1ps
`include "clkgen_config.svh"

module clkdiv_top import clkgen_pkg::*; (
   input  logic                  clk,
   input  logic                  nreset,     // async, active low
   input  logic                  clkchange,  // one-cycle config change pulse
   input  logic                  clken,      // counter enable level
   input  logic [`CLKDIV_CW-1:0] clkdiv,     // 0 bypass, 1 div2, n div n+1
   input  logic [`CLKDIV_PW-1:0] clkphase0,  // {fall, rise} for output 0
   input  logic [`CLKDIV_PW-1:0] clkphase1,  // {fall, rise} for output 1
   output logic                  clkout0,
   output logic                  clkrise0,
   output logic                  clkfall0,
   output logic                  clkout1,
   output logic                  clkrise1,
   output logic                  clkfall1,
   output logic                  clkstable
);

   logic [`CLKDIV_CW-1:0] count;  // shared cycle count
   clk_mode_t             mode;   // decoded from clkdiv
   logic                  wave0;
   logic                  wave1;

   // ####################
   // counter stage
   // ####################
   clkdiv_counter u_counter (
      .clk       (clk),
      .nreset    (nreset),
      .clkchange (clkchange),
      .clken     (clken),
      .clkdiv    (clkdiv),
      .count     (count),
      .mode      (mode),
      .clkstable (clkstable)
   );

   // ####################
   // edge stage
   // ####################
   clkdiv_edges u_edges (
      .clk       (clk),
      .nreset    (nreset),
      .count     (count),
      .clkphase0 (clkphase0),
      .clkphase1 (clkphase1),
      .clkrise0  (clkrise0),
      .clkfall0  (clkfall0),
      .clkrise1  (clkrise1),
      .clkfall1  (clkfall1),
      .wave0     (wave0),
      .wave1     (wave1)
   );

   // ####################
   // output select
   // ####################
   // output 0 keeps the waveform unshifted in every divide mode
   clkdiv_outsel #(
      .HALF_SHIFT (1'b0)
   ) u_out0 (
      .clk    (clk),
      .nreset (nreset),
      .mode   (mode),
      .wave   (wave0),
      .clkout (clkout0)
   );

   // output 1 gets the centred divide-by-2
   clkdiv_outsel #(
      .HALF_SHIFT (1'b1)
   ) u_out1 (
      .clk    (clk),
      .nreset (nreset),
      .mode   (mode),
      .wave   (wave1),
      .clkout (clkout1)
   );

endmodule

// ==== hw/clkdiv_outsel.sv ====
/* mode should only move while clk is low; the latch and mux are behavioural
   and need a real clock-gating cell for timing-clean silicon */
`timescale 1ns/1ps

module clkdiv_outsel import clkgen_pkg::*; #(
   parameter bit HALF_SHIFT = 1'b0  // 1 delays wave by half a clock in mode_half
) (
   input  logic      clk,
   input  logic      nreset,  // async, active low
   input  clk_mode_t mode,    // from counter stage
   input  logic      wave,    // shaped waveform register
   output logic      clkout
);

   // one-hot select codes, bit order matches the mux below
   localparam logic [2:0] SEL_WAVE = 3'b001;
   localparam logic [2:0] SEL_HALF = 3'b010;
   localparam logic [2:0] SEL_CLK  = 3'b100;

   logic [2:0] sel_next;   // decoded from mode
   logic [2:0] sel_lat;    // held over the clk high phase
   logic       wave_half;  // source for mode_half

   // ####################
   // select decode
   // ####################
   always_comb begin
      case (mode)
         mode_bypass: sel_next = SEL_CLK;
         mode_half:   sel_next = SEL_HALF;
         default:     sel_next = SEL_WAVE;   // mode_div
      endcase
   end

   // ####################
   // select latch
   // ####################
   // transparent while clk is low, closed during the high phase
   always_latch begin
      if (!nreset) begin
         sel_lat <= SEL_WAVE;    // wave is 0 in reset, keeps output quiet
      end else if (!clk) begin
         sel_lat <= sel_next;
      end
   end

   // ####################
   // half-cycle shift
   // ####################
   if (HALF_SHIFT) begin : g_shift

      logic wave_sh;

      // negedge capture centres the divide-by-2 clock
      always_ff @(negedge clk or negedge nreset) begin
         if (!nreset) begin
            wave_sh <= 1'b0;
         end else begin
            wave_sh <= wave;
         end
      end

      assign wave_half = wave_sh;

   end else begin : g_direct

      assign wave_half = wave;   // no shift on this output

   end

   // ####################
   // clock mux
   // ####################
   // and-or form, only one leg can be open at a time
   assign clkout = (sel_lat[0] & wave)
                 | (sel_lat[1] & wave_half)
                 | (sel_lat[2] & clk);

   // a select with two legs open would merge two clocks on the output
   a_sel_onehot: assert property (
      @(posedge clk) disable iff (!nreset)
      $onehot(sel_lat)
   );

endmodule

// ==== hw/clkdiv_edges.sv ====
/* phase halves are not checked against the period; a rise or fall value
   above clkdiv simply never matches */
`timescale 1ns/1ps
`include "clkgen_config.svh"

module clkdiv_edges (
   input  logic                  clk,
   input  logic                  nreset,     // async, active low
   input  logic [`CLKDIV_CW-1:0] count,      // from counter stage
   input  logic [`CLKDIV_PW-1:0] clkphase0,  // {fall, rise} for output 0
   input  logic [`CLKDIV_PW-1:0] clkphase1,  // {fall, rise} for output 1
   output logic                  clkrise0,
   output logic                  clkfall0,
   output logic                  clkrise1,
   output logic                  clkfall1,
   output logic                  wave0,      // shaped waveform, output 0
   output logic                  wave1       // shaped waveform, output 1
);

   localparam int NOUT = 2;

   logic [`CLKDIV_PW-1:0] phase [NOUT];
   logic [NOUT-1:0]       rise;     // count equals rise half
   logic [NOUT-1:0]       fall;     // count equals fall half
   logic [NOUT-1:0]       wave_q;   // waveform registers

   assign phase[0] = clkphase0;
   assign phase[1] = clkphase1;

   // ####################
   // match decode and
   // waveform registers
   // ####################
   for (genvar i = 0; i < NOUT; i++) begin : g_out

      // strobes are plain compares, both may be high at once
      assign rise[i] = (count == phase[i][`CLKDIV_CW-1:0]);
      assign fall[i] = (count == phase[i][`CLKDIV_PW-1:`CLKDIV_CW]);

      always_ff @(posedge clk or negedge nreset) begin
         if (!nreset) begin
            wave_q[i] <= 1'b0;
         end else if (rise[i]) begin
            wave_q[i] <= 1'b1;        // rise wins over fall
         end else if (fall[i]) begin
            wave_q[i] <= 1'b0;
         end
      end

   end

   // ####################
   // outputs
   // ####################
   assign clkrise0 = rise[0];
   assign clkfall0 = fall[0];
   assign clkrise1 = rise[1];
   assign clkfall1 = fall[1];

   // one cycle behind the strobes
   assign wave0 = wave_q[0];
   assign wave1 = wave_q[1];

endmodule

// ==== hw/clkdiv_counter.sv ====
/* clkdiv must only change together with a clkchange pulse
   period 0 is bypass, n>0 divides by n+1 */
`timescale 1ns/1ps
`include "clkgen_config.svh"

module clkdiv_counter import clkgen_pkg::*; (
   input  logic                  clk,
   input  logic                  nreset,    // async, active low
   input  logic                  clkchange, // config changed this cycle
   input  logic                  clken,     // lets the counter advance
   input  logic [`CLKDIV_CW-1:0] clkdiv,    // period value
   output logic [`CLKDIV_CW-1:0] count,
   output clk_mode_t             mode,
   output logic                  clkstable
);

   localparam int STW = $clog2(`CLKDIV_STABLE_PERIODS);   // detector width
   localparam logic [STW-1:0] ST_MAX = STW'(`CLKDIV_STABLE_PERIODS - 1);

   logic           period_match;  // last cycle of the period
   logic [STW-1:0] stable_cnt;    // matches seen since last change

   // ####################
   // cycle counter
   // ####################
   assign period_match = (count == clkdiv);

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         count <= '0;
      end else if (clken) begin
         if (period_match) begin
            count <= '0;              // wrap, period is clkdiv+1 cycles
         end else begin
            count <= count + 1'b1;
         end
      end
      // clken low holds the count and so the waveforms
   end

   // ####################
   // mode decode
   // ####################
   // the only place the period value is turned into a mode
   always_comb begin
      if (clkdiv == '0) begin
         mode = mode_bypass;
      end else if (clkdiv == `CLKDIV_CW'(1)) begin
         mode = mode_half;
      end else begin
         mode = mode_div;
      end
   end

   // ####################
   // change / stable detect
   // ####################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         stable_cnt <= '0;
      end else if (clkchange) begin
         stable_cnt <= '0;            // restart on any config change
      end else if (period_match && !clkstable) begin
         stable_cnt <= stable_cnt + 1'b1;  // saturates at ST_MAX
      end
   end

   assign clkstable = (stable_cnt == ST_MAX);

   // flag must drop right after a change
   a_stable_drop: assert property (
      @(posedge clk) disable iff (!nreset)
      clkchange |=> !clkstable
   );

   // once a wrap was seen since the last change the count stays in range
   // (a fresh change may leave count above the new period until it wraps)
   a_count_range: assert property (
      @(posedge clk) disable iff (!nreset)
      (clken && !clkchange && (stable_cnt != '0)) |-> (count <= clkdiv)
   );

endmodule

// ==== hw/clkgen_pkg.sv ====
/* output source modes decoded from the period value */
package clkgen_pkg;

   // ####################
   // output mode
   // ####################
   // period 0 bypasses the divider
   // period 1 gives divide by 2, the only case with a half-cycle shift
   // anything larger runs the shaped waveform
   typedef enum logic [1:0] {
      mode_bypass = 2'd0, // pass raw clk
      mode_half   = 2'd1, // divide by 2
      mode_div    = 2'd2  // divide by n+1
   } clk_mode_t;

   // 2'd3 is never decoded

endpackage

// ==== hw/clkgen_config.svh ====
/* widths and stable count shared by the RTL and the testbench
   phase word is two counter-sized halves, rise low and fall high */
`ifndef CLKGEN_CONFIG_SVH
`define CLKGEN_CONFIG_SVH

// ####################
// counter and phase
// ####################
`define CLKDIV_CW 8              // counter and period width
`define CLKDIV_PW 16             // phase word, {fall, rise}

// ####################
// stability detector
// ####################
// periods without a change before clkstable rises
// must stay a power of two so the detector saturates at all ones
`define CLKDIV_STABLE_PERIODS 8

`endif
